// File: project.f
+incdir+source
source/uart_frame_pkg.sv
source/cmd_pkg.sv
source/byte_fifo.sv
source/uart_tx_serializer.sv
source/uart_rx_deserializer.sv
source/cmd_sequencer.sv
source/uart_cmd_bridge.sv
tests/tb_remote_device.sv
tests/tb_uart_bridge.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_uart_bridge
FILELIST := project.f

BUILD    := obj_dir
SIM_BIN  := $(BUILD)/V$(TOP)
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS  := $(wildcard source/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD)

// File: tests/tb_uart_bridge.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module tb_uart_bridge;

  localparam int CPB = `UART_CLKS_PER_BIT;
  localparam int FRAME_CLKS = `UART_FRAME_BITS * CPB;
  localparam int NUM_CMDS = 40;
  localparam int WAIT_LIMIT = 20 * FRAME_CLKS;
  localparam int HOLD_CYCLES = 4;

  logic                 clk;
  logic                 rst_n;
  cmd_pkg::bridge_cmd_u cmd_in;
  logic                 cmd_vld;
  logic                 rx;
  logic                 cmd_rdy;
  logic                 tx;
  logic                 read_rdy;
  logic [8:0]           read_data;
  logic                 bad_parity;
  logic                 frame_done;
  logic [7:0]           frame_byte;
  logic                 frame_ok;
  logic                 dev_timeout;

  logic [31:0]          lfsr;
  logic [7:0]           model_mem [128];
  logic [7:0]           frame_q [$];
  int                   cycle = 0;

  uart_cmd_bridge DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  tb_remote_device remote (
    .clk        (clk),
    .tx         (tx),
    .bad_parity (bad_parity),
    .rx         (rx),
    .frame_done (frame_done),
    .frame_byte (frame_byte),
    .frame_ok   (frame_ok),
    .timed_out  (dev_timeout)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (dev_timeout) begin
      abort_run("remote device saw no start bit on tx for 20 frames");
    end
    if (frame_done) begin
      if (!frame_ok) begin
        abort_run("tx frame with a bad start bit, parity bit or stop bit");
      end
      frame_q.push_back(frame_byte);
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [15:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      val[i] = lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("[ERROR] %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_cmd(input cmd_pkg::bridge_cmd_u got, input cmd_pkg::bridge_cmd_u exp);
    if (got.rd.rw !== exp.rd.rw || got.rd.addr !== exp.rd.addr ||
        (exp.wr.rw == cmd_pkg::CMD_WRITE && got.wr.data !== exp.wr.data)) begin
      abort_run($sformatf("[ERROR] %0t: tx command got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_read(input logic [8:0] got, input logic [8:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t: read_data got %h expected %h", $time, got, exp));
    end
  endtask

  // starts and ends on a falling edge
  task automatic run_command(input cmd_pkg::bridge_cmd_u cmd, input logic corrupt);
    cmd_pkg::bridge_cmd_u got_cmd;
    logic [8:0]           got_read;
    logic                 is_read;
    int                   t;
    int                   acc_cycle;
    int                   pulses;
    is_read = cmd.rd.rw == cmd_pkg::CMD_READ;
    bad_parity = corrupt;
    cmd_in = cmd;
    cmd_vld = 1'b1;
    t = 0;
    while (!cmd_rdy) begin
      if (t == WAIT_LIMIT) begin
        abort_run("command was never accepted");
      end
      @(negedge clk);
      t++;
    end
    @(negedge clk);
    acc_cycle = cycle;
    check_bit("cmd_rdy", cmd_rdy, 1'b0);
    // cmd_vld stays up for a while and must not start a second transfer
    pulses = 0;
    got_read = '0;
    t = 0;
    while (!cmd_rdy) begin
      if (t == WAIT_LIMIT) begin
        abort_run("cmd_rdy did not return after the command");
      end
      if (t == HOLD_CYCLES) begin
        cmd_vld = 1'b0;
      end
      @(negedge clk);
      t++;
      if (read_rdy) begin
        pulses++;
        got_read = read_data;
      end
    end
    check_bit("read_rdy", read_rdy, is_read);
    check_count("read_rdy pulses", pulses, is_read ? 1 : 0);
    if (!is_read) begin
      check_count("write latency", cycle - acc_cycle, 2 * FRAME_CLKS + 3);
    end
    @(negedge clk);
    check_bit("read_rdy", read_rdy, 1'b0);
    check_count("tx frames", frame_q.size(), is_read ? 1 : 2);
    got_cmd = {frame_q[0], is_read ? 8'h00 : frame_q[1]};
    frame_q.delete();
    check_cmd(got_cmd, cmd);
    if (is_read) begin
      check_read(got_read, {corrupt, model_mem[cmd.rd.addr]});
    end else begin
      model_mem[cmd.wr.addr] = cmd.wr.data;
    end
  endtask

  initial begin
    cmd_pkg::bridge_cmd_u cmd;
    logic [15:0]          r;
    logic                 corrupt;
    int                   i;
    rst_n = 1'b0;
    cmd_in = '0;
    cmd_vld = 1'b0;
    bad_parity = 1'b0;
    lfsr = 32'h51350697;
    for (i = 0; i < 128; i++) begin
      model_mem[i] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // quiet line after reset
    repeat (20) begin
      @(negedge clk);
      check_bit("tx", tx, 1'b1);
      check_bit("cmd_rdy", cmd_rdy, 1'b1);
      check_bit("read_rdy", read_rdy, 1'b0);
    end
    for (i = 0; i < NUM_CMDS; i++) begin
      draw_bits(1, r);
      cmd.wr.rw = r[0];
      // narrow address range so reads land on earlier writes
      draw_bits(7, r);
      cmd.wr.addr = r[6:0] & 7'h0f;
      draw_bits(8, r);
      cmd.wr.data = r[7:0];
      corrupt = 1'b0;
      if (cmd.rd.rw == cmd_pkg::CMD_READ) begin
        draw_bits(2, r);
        corrupt = &r[1:0];
      end
      run_command(cmd, corrupt);
    end
    // no late frame once the last command has finished
    repeat (FRAME_CLKS + CPB) @(negedge clk);
    check_count("tx frames after last command", frame_q.size(), 0);
    check_bit("tx", tx, 1'b1);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: tests/tb_remote_device.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module tb_remote_device (
  input  logic       clk,
  input  logic       tx,
  input  logic       bad_parity,
  output logic       rx,
  output logic       frame_done,
  output logic [7:0] frame_byte,
  output logic       frame_ok,
  output logic       timed_out
);

  localparam int CPB = `UART_CLKS_PER_BIT;
  localparam int FB = `UART_FRAME_BITS;
  localparam int WAIT_LIMIT = 20 * CPB * FB;

  // register file on the far side of the link
  logic [7:0]  regs [128];
  logic        data_next;
  logic [6:0]  wr_addr;
  logic [10:0] bits;
  logic [7:0]  rbyte;
  logic        seen;

  // idle line between commands, start bit expected soon
  task automatic wait_start(output logic found);
    int t;
    found = 1'b0;
    t = 0;
    while (!found && t < WAIT_LIMIT) begin
      @(negedge clk);
      frame_done = 1'b0;
      t++;
      if (tx === 1'b0) begin
        found = 1'b1;
      end
    end
  endtask

  // called half a cycle after the falling start edge
  task automatic read_frame(output logic [10:0] fbits);
    int i;
    fbits = '0;
    repeat (CPB / 2 - 1) @(negedge clk);
    for (i = 0; i < FB; i++) begin
      if (i > 0) begin
        repeat (CPB) @(negedge clk);
      end
      fbits[i] = tx;
    end
  endtask

  task automatic send_response(input logic [7:0] data);
    logic [10:0] frame;
    int i;
    // odd parity over data and parity, flipped on request
    frame = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};
    @(negedge clk);
    frame_done = 1'b0;
    repeat (2 * CPB - 1) @(negedge clk);
    for (i = 0; i < FB; i++) begin
      rx = frame[i];
      repeat (CPB) @(negedge clk);
    end
    rx = 1'b1;
  endtask

  initial begin
    int i;
    rx = 1'b1;
    frame_done = 1'b0;
    frame_byte = '0;
    frame_ok = 1'b1;
    timed_out = 1'b0;
    data_next = 1'b0;
    wr_addr = '0;
    for (i = 0; i < 128; i++) begin
      regs[i] = '0;
    end
    while (!timed_out) begin
      wait_start(seen);
      if (!seen) begin
        timed_out = 1'b1;
      end else begin
        read_frame(bits);
        rbyte = bits[8:1];
        frame_byte = rbyte;
        frame_ok = (bits[0] == 1'b0) && ((^bits[9:1]) == 1'b1) && (bits[10] == 1'b1);
        frame_done = 1'b1;
        if (data_next) begin
          regs[wr_addr] = rbyte;
          data_next = 1'b0;
        end else if (rbyte[7]) begin
          send_response(regs[rbyte[6:0]]);
        end else begin
          wr_addr = rbyte[6:0];
          data_next = 1'b1;
        end
      end
    end
  end

endmodule

// File: source/uart_cmd_bridge.sv
`timescale 1ns/1ps

module uart_cmd_bridge (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cmd_pkg::bridge_cmd_u cmd_in,
  input  logic                 cmd_vld,
  input  logic                 rx,
  output logic                 cmd_rdy,
  output logic                 tx,
  output logic                 read_rdy,
  output logic [8:0]           read_data
);

  logic       push;
  logic [7:0] push_data;
  logic       full;
  logic       pop;
  logic [7:0] pop_data;
  logic       empty;
  logic       byte_sent;
  logic       rx_valid;
  logic [8:0] rx_result;

  cmd_sequencer u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .full      (full),
    .byte_sent (byte_sent),
    .rx_valid  (rx_valid),
    .rx_result (rx_result),
    .cmd_rdy   (cmd_rdy),
    .push      (push),
    .push_data (push_data),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  byte_fifo u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .full      (full),
    .empty     (empty)
  );

  uart_tx_serializer u_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .empty     (empty),
    .pop_data  (pop_data),
    .pop       (pop),
    .tx        (tx),
    .byte_sent (byte_sent)
  );

  uart_rx_deserializer u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_valid  (rx_valid),
    .rx_result (rx_result)
  );

endmodule

// File: source/cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cmd_pkg::bridge_cmd_u cmd_in,
  input  logic                 cmd_vld,
  input  logic                 full,
  input  logic                 byte_sent,
  input  logic                 rx_valid,
  input  logic [8:0]           rx_result,
  output logic                 cmd_rdy,
  output logic                 push,
  output logic [7:0]           push_data,
  output logic                 read_rdy,
  output logic [8:0]           read_data
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_PUSH = 2'd1;
  localparam logic [1:0] S_SEND = 2'd2;
  localparam logic [1:0] S_RESP = 2'd3;

  logic [1:0]           state;
  cmd_pkg::bridge_cmd_u cmd_q;
  // 0 picks the rw/addr byte and 1 the write data byte
  logic                 byte_sel;
  logic [1:0]           pushed_cnt;
  logic [1:0]           sent_cnt;
  logic                 accept;
  logic                 is_write;
  logic                 last_byte;

  assign accept = cmd_vld && cmd_rdy;
  assign is_write = cmd_q.wr.rw == cmd_pkg::CMD_WRITE;
  assign last_byte = byte_sel || !is_write;

  assign push = (state == S_PUSH) && !full;
  assign push_data = byte_sel ? cmd_q.wr.data : {cmd_q.rd.rw, cmd_q.rd.addr};

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
    if (state == S_RESP && rx_valid) begin
      read_data <= rx_result;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
      cmd_rdy <= 1'b1;
      byte_sel <= 1'b0;
      pushed_cnt <= 2'd0;
      sent_cnt <= 2'd0;
      read_rdy <= 1'b0;
    end else begin
      read_rdy <= 1'b0;
      case (state)
        S_IDLE: begin
          if (accept) begin
            state <= S_PUSH;
            cmd_rdy <= 1'b0;
            byte_sel <= 1'b0;
            pushed_cnt <= 2'd0;
            sent_cnt <= 2'd0;
          end
        end
        S_PUSH: begin
          if (push) begin
            pushed_cnt <= pushed_cnt + 2'd1;
            if (last_byte) begin
              state <= S_SEND;
            end else begin
              byte_sel <= 1'b1;
            end
          end
        end
        S_SEND: begin
          // every pushed byte has left on tx
          if (sent_cnt == pushed_cnt) begin
            if (is_write) begin
              state <= S_IDLE;
              cmd_rdy <= 1'b1;
            end else begin
              state <= S_RESP;
            end
          end
        end
        default: begin
          if (rx_valid) begin
            read_rdy <= 1'b1;
            cmd_rdy <= 1'b1;
            state <= S_IDLE;
          end
        end
      endcase
      if (state != S_IDLE && byte_sent) begin
        sent_cnt <= sent_cnt + 2'd1;
      end
    end
  end

  // buffer has drained by the time a new command starts pushing
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    state == S_PUSH |-> !full
  );

  // a response byte only comes back while a read waits for it
  a_rx_valid_in_read: assert property (
    @(posedge clk) disable iff (!rst_n)
    rx_valid |-> state == S_RESP
  );

endmodule

// File: source/uart_rx_deserializer.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rx_deserializer (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic       rx_valid,
  output logic [8:0] rx_result
);

  localparam int CPB = `UART_CLKS_PER_BIT;
  localparam int FB = `UART_FRAME_BITS;
  localparam int CNT_W = $clog2(CPB);
  localparam int BIT_W = $clog2(FB);

  localparam logic [BIT_W-1:0] START_IDX = BIT_W'(uart_frame_pkg::START_POS);
  localparam logic [BIT_W-1:0] DATA_LO_IDX = BIT_W'(uart_frame_pkg::DATA_LSB_POS);
  localparam logic [BIT_W-1:0] DATA_HI_IDX = BIT_W'(uart_frame_pkg::DATA_MSB_POS);
  localparam logic [BIT_W-1:0] PARITY_IDX = BIT_W'(uart_frame_pkg::PARITY_POS);
  localparam logic [BIT_W-1:0] STOP_IDX = BIT_W'(uart_frame_pkg::STOP_POS);

  // two sync stages, third stage only for edge detect
  logic [2:0]       rx_sh;
  logic             rx_bit;
  logic             start_edge;
  logic             busy;
  logic [CNT_W-1:0] clk_cnt;
  logic [BIT_W-1:0] bit_idx;
  logic             mid_tick;
  logic             end_tick;
  logic [7:0]       data_q;
  logic             par_q;
  logic             stop_q;

  assign rx_bit = rx_sh[1];
  assign start_edge = rx_sh[2] && !rx_sh[1];
  assign mid_tick = clk_cnt == CNT_W'(CPB / 2 - 1);
  assign end_tick = clk_cnt == CNT_W'(CPB - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sh <= '1;
    end else begin
      rx_sh <= {rx_sh[1:0], rx};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!busy) begin
        if (start_edge) begin
          busy <= 1'b1;
          clk_cnt <= '0;
          bit_idx <= START_IDX;
        end
      end else if (mid_tick && bit_idx == START_IDX && rx_bit != uart_frame_pkg::START_BIT) begin
        // line went back high, just a glitch
        busy <= 1'b0;
      end else if (end_tick) begin
        clk_cnt <= '0;
        if (bit_idx == STOP_IDX) begin
          busy <= 1'b0;
          rx_valid <= 1'b1;
        end else begin
          bit_idx <= bit_idx + 1'b1;
        end
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (busy && mid_tick) begin
      if (bit_idx >= DATA_LO_IDX && bit_idx <= DATA_HI_IDX) begin
        data_q <= {rx_bit, data_q[7:1]};
      end
      if (bit_idx == PARITY_IDX) begin
        par_q <= rx_bit;
      end
      if (bit_idx == STOP_IDX) begin
        stop_q <= rx_bit;
      end
    end
    // error flag covers bad parity and a low stop bit
    if (busy && end_tick && bit_idx == STOP_IDX) begin
      rx_result <= {(par_q != uart_frame_pkg::odd_parity(data_q)) ||
                    (stop_q != uart_frame_pkg::STOP_BIT), data_q};
    end
  end

endmodule

// File: source/uart_tx_serializer.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tx_serializer (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       empty,
  input  logic [7:0] pop_data,
  output logic       pop,
  output logic       tx,
  output logic       byte_sent
);

  localparam int CPB = `UART_CLKS_PER_BIT;
  localparam int FB = `UART_FRAME_BITS;
  localparam int CNT_W = $clog2(CPB);
  localparam int BIT_W = $clog2(FB);

  logic             busy;
  logic [CNT_W-1:0] clk_cnt;
  logic [BIT_W-1:0] bit_idx;
  logic [FB-1:0]    frame_q;
  logic [FB-1:0]    next_frame;
  logic             last_tick;
  logic             frame_end;

  always_comb begin
    next_frame = '1;
    next_frame[uart_frame_pkg::START_POS] = uart_frame_pkg::START_BIT;
    next_frame[uart_frame_pkg::DATA_MSB_POS:uart_frame_pkg::DATA_LSB_POS] = pop_data;
    next_frame[uart_frame_pkg::PARITY_POS] = uart_frame_pkg::odd_parity(pop_data);
    next_frame[uart_frame_pkg::STOP_POS] = uart_frame_pkg::STOP_BIT;
  end

  assign last_tick = clk_cnt == CNT_W'(CPB - 1);
  assign frame_end = busy && last_tick && (bit_idx == BIT_W'(FB - 1));
  assign byte_sent = frame_end;
  // reload in the stop bit's last cycle so bytes go out without a gap
  assign pop = (!busy || frame_end) && !empty;

  always_ff @(posedge clk) begin
    if (pop) begin
      frame_q <= next_frame;
    end else if (busy && last_tick) begin
      frame_q <= {1'b1, frame_q[FB-1:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx <= 1'b1;
    end else if (pop) begin
      busy <= 1'b1;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx <= next_frame[uart_frame_pkg::START_POS];
    end else if (busy) begin
      if (frame_end) begin
        busy <= 1'b0;
        clk_cnt <= '0;
      end else if (last_tick) begin
        clk_cnt <= '0;
        bit_idx <= bit_idx + 1'b1;
        tx <= frame_q[1];
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

  a_idle_line_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    !busy |-> tx
  );

endmodule

// File: source/byte_fifo.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module byte_fifo (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push,
  input  logic [7:0] push_data,
  input  logic       pop,
  output logic [7:0] pop_data,
  output logic       full,
  output logic       empty
);

  localparam int DEPTH = `BYTE_FIFO_DEPTH;
  localparam int AW = $clog2(DEPTH);

  logic [7:0]  mem [DEPTH];
  // extra msb tells a full buffer from an empty one
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        do_push;
  logic        do_pop;

  assign do_push = push && !full;
  assign do_pop = pop && !empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[AW-1:0]] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  assign pop_data = mem[rd_ptr[AW-1:0]];
  assign empty = wr_ptr == rd_ptr;
  assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    push |-> !full
  );

  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    pop |-> !empty
  );

endmodule

// File: source/cmd_pkg.sv
package cmd_pkg;

  // read/write flag in bit 15
  localparam logic CMD_WRITE = 1'b0;
  localparam logic CMD_READ = 1'b1;

  // one 16-bit command word, two layouts
  typedef union packed {
    struct packed {
      logic       rw;
      logic [6:0] addr;
      logic [7:0] data;
    } wr;
    // low byte carries nothing on a read
    struct packed {
      logic       rw;
      logic [6:0] addr;
      logic [7:0] unused;
    } rd;
  } bridge_cmd_u;

endpackage

// File: source/uart_frame_pkg.sv
package uart_frame_pkg;

  // line levels
  localparam logic START_BIT = 1'b0;
  localparam logic STOP_BIT = 1'b1;

  // bit slots within a frame, slot 0 goes out first
  localparam int START_POS = 0;
  localparam int DATA_LSB_POS = 1;
  localparam int DATA_MSB_POS = 8;
  localparam int PARITY_POS = 9;
  localparam int STOP_POS = 10;

  // parity bit that leaves an odd count of ones over data and parity
  function automatic logic odd_parity(input logic [7:0] data);
    return ~(^data);
  endfunction

endpackage

// File: source/uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// clocks spent on each bit of a frame
`define UART_CLKS_PER_BIT 16

// start, eight data, parity, stop
`define UART_FRAME_BITS 11

// byte buffer between sequencer and serializer, power of two
`define BYTE_FIFO_DEPTH 4

`endif
